//--- Bender.yml
package:
  name: cpu_control

sources:
  - files:
      - design/controlPkg.sv
      - design/instrDecode.sv
      - design/cycleSequencer.sv
      - design/statusFlags.sv
      - design/strobeGen.sv
      - design/cpuControl.sv
  - target: test
    files:
      - verif/cpuControlTb.sv

//--- design/controlPkg.sv
// Control package with the opcode, select and state encodings and the control words
`default_nettype none

package controlPkg;

   localparam int OpcodeW = 5;
   localparam int BranchW = 3;
   localparam int FlagsW = 4;

   localparam int FlagZ = 3;
   localparam int FlagN = 2;
   localparam int FlagV = 1;
   localparam int FlagC = 0;

   typedef enum logic [OpcodeW-1:0] {
      ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI,
      CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG,
      LUI, LLI, LDW, STW, BRANCH
   } opcodeT;

   typedef enum logic [BranchW-1:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branchT;

   typedef enum logic [4:0] {
      FnA, FnADD, FnADC, FnSUB, FnSUC, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFnT;

   typedef enum logic [1:0] {Op1Rd1, Op1Pc} op1SelT;
   typedef enum logic [1:0] {Op2Imm, Op2Rd2} op2SelT;
   typedef enum logic [1:0] {ImmLong, ImmShort} immSelT;
   typedef enum logic [1:0] {WdAlu, WdSys} wdSelT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelT;
   typedef enum logic [1:0] {LrSys, LrPc} lrSelT;
   typedef enum logic [1:0] {Rs1Ra, Rs1Rd} rs1SelT;

   typedef enum logic {Fetch, Execute} majorStateT;

   typedef enum logic [2:0] {
      Cycle0, Cycle1, Cycle2, Cycle3, Cycle4
   } subCycleT;

   typedef enum logic [1:0] {ClsAlu, ClsMem, ClsBranch} instrClassT;

   typedef struct packed {
      opcodeT     opcode;
      branchT     branch;
      instrClassT cls;
      aluFnT      aluFn;
      op2SelT     op2Sel;
      immSelT     immSel;
      rs1SelT     rs1Sel;
      logic       regWrite;   // Result goes to the register file
      logic       flagUpdate; // Status register takes the ALU flags
   } decodedT;

   typedef struct packed {
      aluFnT  aluOp;
      op1SelT op1Sel;
      op2SelT op2Sel;
      immSelT immSel;
      wdSelT  wdSel;
      pcSelT  pcSel;
      lrSelT  lrSel;
      rs1SelT rs1Sel;
      logic   regWe;
      logic   pcWe;
      logic   aluWe;
      logic   irWe;
      logic   lrWe;
      logic   aluEn;
      logic   pcEn;
      logic   lrEn;
   } dpCtrlT;

   typedef struct packed {
      logic memEn;   // Pad direction
      logic nWE;
      logic nOE;
      logic nME;
      logic enb;
      logic ale;
   } memCtrlT;

   typedef struct packed {
      majorStateT major;
      subCycleT   sub;
   } seqStateT;

   localparam seqStateT SeqStart = '{major: Fetch, sub: Cycle0};

   // Idle datapath word, nothing enabled and nothing written
   localparam dpCtrlT DpIdle = '{
      aluOp: FnA, op1Sel: Op1Rd1, op2Sel: Op2Imm, immSel: ImmLong,
      wdSel: WdAlu, pcSel: Pc1, lrSel: LrSys, rs1Sel: Rs1Ra,
      regWe: 1'b0, pcWe: 1'b0, aluWe: 1'b0, irWe: 1'b0,
      lrWe: 1'b0, aluEn: 1'b0, pcEn: 1'b0, lrEn: 1'b0
   };

   localparam memCtrlT MemIdle = '{
      memEn: 1'b0, nWE: 1'b0, nOE: 1'b0, nME: 1'b1, enb: 1'b0, ale: 1'b0
   };

endpackage

`default_nettype wire

//--- design/cpuControl.sv
// Instruction control unit top, ties decode, sequencer, flags and strobes together
`default_nettype none

module cpuControl (
   input  wire logic                          Clock,
   input  wire logic                          nReset,
   input  wire logic                          nWait,
   input  wire logic [7:0]                    OpcodeCondIn,
   input  wire logic [controlPkg::FlagsW-1:0] Flags,
   output controlPkg::dpCtrlT                 DpCtrl,
   output controlPkg::memCtrlT                MemCtrl,
   output logic                               CFlag
);

   import controlPkg::*;

   decodedT  decoded;
   seqStateT seqState;
   logic     flagWe;
   logic     branchTaken;

   instrDecode instrDecode_i (
      .OpcodeCondIn (OpcodeCondIn),
      .Decoded      (decoded)
   );

   cycleSequencer cycleSequencer_i (
      .Clock    (Clock),
      .nReset   (nReset),
      .nWait    (nWait),
      .Decoded  (decoded),
      .SeqState (seqState)
   );

   statusFlags statusFlags_i (
      .Clock       (Clock),
      .nReset      (nReset),
      .FlagWe      (flagWe),
      .Flags       (Flags),
      .Branch      (decoded.branch),
      .BranchTaken (branchTaken),
      .CFlag       (CFlag)
   );

   strobeGen strobeGen_i (
      .Decoded     (decoded),
      .SeqState    (seqState),
      .BranchTaken (branchTaken),
      .DpCtrl      (DpCtrl),
      .MemCtrl     (MemCtrl),
      .FlagWe      (flagWe)
   );

endmodule

`default_nettype wire

//--- design/cycleSequencer.sv
// Fetch and execute sequencer, walks the major state and sub-cycle with nWait stalls
`default_nettype none

module cycleSequencer (
   input  wire logic              Clock,
   input  wire logic              nReset,
   input  wire logic              nWait,
   input  wire controlPkg::decodedT Decoded,
   output controlPkg::seqStateT   SeqState
);

   import controlPkg::*;

   seqStateT nextState;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         SeqState <= SeqStart;
      end else begin
         SeqState <= nextState;
      end
   end

   always_comb begin
      nextState = SeqState;
      if (SeqState.major == Fetch) begin
         case (SeqState.sub)
            Cycle0: nextState.sub = Cycle1;
            Cycle1: nextState.sub = Cycle2;
            Cycle2: begin
               if (nWait)
                  nextState.sub = Cycle3;   // Hold until memory is ready
            end
            default: begin
               nextState.major = Execute;
               nextState.sub = Cycle0;
            end
         endcase
      end else begin
         case (SeqState.sub)
            Cycle0: begin
               if (Decoded.cls == ClsMem)
                  nextState.sub = Cycle1;
               else
                  nextState = SeqStart;     // Single cycle op done
            end
            Cycle1: nextState.sub = Cycle2;
            Cycle2: nextState.sub = Cycle3;
            Cycle3: begin
               if (nWait)
                  nextState.sub = Cycle4;   // Data phase stall
            end
            default: nextState = SeqStart;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/instrDecode.sv
// Instruction decoder, splits the opcode byte and sets up class and ALU operation
`default_nettype none

module instrDecode (
   input  wire logic [7:0]       OpcodeCondIn,
   output controlPkg::decodedT   Decoded
);

   import controlPkg::*;

   always_comb begin
      Decoded.opcode = opcodeT'(OpcodeCondIn[BranchW +: OpcodeW]);
      Decoded.branch = branchT'(OpcodeCondIn[BranchW-1:0]);
      Decoded.cls = ClsAlu;
      Decoded.aluFn = FnA;
      Decoded.op2Sel = Op2Imm;
      Decoded.immSel = ImmLong;
      Decoded.rs1Sel = Rs1Ra;
      Decoded.regWrite = 1'b0;
      Decoded.flagUpdate = 1'b0;

      case (Decoded.opcode)
         ADD, ADDI, ADDIB:             Decoded.aluFn = FnADD;
         ADC, ADCI:                    Decoded.aluFn = FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI:  Decoded.aluFn = FnSUB;
         SUC, SUCI:                    Decoded.aluFn = FnSUC;
         AND:                          Decoded.aluFn = FnAND;
         OR:                           Decoded.aluFn = FnOR;
         XOR:                          Decoded.aluFn = FnXOR;
         NOT:                          Decoded.aluFn = FnNOT;
         NAND:                         Decoded.aluFn = FnNAND;
         NOR:                          Decoded.aluFn = FnNOR;
         LSL:                          Decoded.aluFn = FnLSL;
         LSR:                          Decoded.aluFn = FnLSR;
         ASR:                          Decoded.aluFn = FnASR;
         NEG:                          Decoded.aluFn = FnNEG;
         LUI:                          Decoded.aluFn = FnLUI;
         LLI:                          Decoded.aluFn = FnLLI;
         LDW, STW: begin
            Decoded.cls = ClsMem;
            Decoded.aluFn = FnADD;     // Base plus offset
         end
         BRANCH: begin
            Decoded.cls = ClsBranch;
            Decoded.aluFn = FnADD;     // Target address
         end
         default:                      Decoded.aluFn = FnA;
      endcase

      case (Decoded.opcode)
         ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR:
            Decoded.op2Sel = Op2Rd2;
         ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR, LDW, STW:
            Decoded.immSel = ImmShort;
         ADDIB, SUBIB, LUI, LLI:
            Decoded.rs1Sel = Rs1Rd;    // Byte forms work on Rd itself
         BRANCH:
            if (Decoded.branch == JMP)
               Decoded.immSel = ImmShort;
         default: ;
      endcase

      // Unused opcodes fall through as a NOP
      if (Decoded.cls == ClsAlu && Decoded.aluFn != FnA) begin
         Decoded.regWrite = !(Decoded.opcode inside {CMP, CMPI});
         Decoded.flagUpdate = !(Decoded.opcode inside {LUI, LLI});
      end
   end

endmodule

`default_nettype wire

//--- design/statusFlags.sv
// Status register with branch condition evaluation and carry flag output
`default_nettype none

module statusFlags (
   input  wire logic                      Clock,
   input  wire logic                      nReset,
   input  wire logic                      FlagWe,
   input  wire logic [controlPkg::FlagsW-1:0] Flags,
   input  wire controlPkg::branchT        Branch,
   output logic                           BranchTaken,
   output logic                           CFlag
);

   import controlPkg::*;

   logic [FlagsW-1:0] statusReg;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (FlagWe) begin
         statusReg <= Flags;
      end
   end

   assign CFlag = statusReg[FlagC];

   always_comb begin
      case (Branch)
         BR, BWL, JMP: BranchTaken = 1'b1;
         BNE:          BranchTaken = !statusReg[FlagZ];
         BE:           BranchTaken = statusReg[FlagZ];
         BLT:          BranchTaken = statusReg[FlagN] != statusReg[FlagV];  // Signed less than
         BGE:          BranchTaken = statusReg[FlagN] == statusReg[FlagV];
         default:      BranchTaken = 1'b0;   // RET returns through the link register
      endcase
   end

endmodule

`default_nettype wire

//--- design/strobeGen.sv
// Strobe generator, datapath control word and memory bus strobes per cycle
`default_nettype none

module strobeGen (
   input  wire controlPkg::decodedT  Decoded,
   input  wire controlPkg::seqStateT SeqState,
   input  wire logic                 BranchTaken,
   output controlPkg::dpCtrlT        DpCtrl,
   output controlPkg::memCtrlT       MemCtrl,
   output logic                      FlagWe
);

   import controlPkg::*;

   always_comb begin
      DpCtrl = DpIdle;
      MemCtrl = MemIdle;
      FlagWe = 1'b0;

      if (SeqState.major == Fetch) begin
         MemCtrl.nWE = 1'b1;
         case (SeqState.sub)
            Cycle0: begin
               MemCtrl.ale = 1'b1;         // Latch PC as address
               MemCtrl.nOE = 1'b1;
               DpCtrl.pcEn = 1'b1;
            end
            Cycle1: begin
               MemCtrl.nME = 1'b0;
               MemCtrl.memEn = 1'b1;
            end
            Cycle2: begin
               MemCtrl.nME = 1'b0;
               MemCtrl.memEn = 1'b1;
               MemCtrl.enb = 1'b1;
            end
            default: begin
               MemCtrl.memEn = 1'b1;
               DpCtrl.irWe = 1'b1;
            end
         endcase
      end else begin
         case (SeqState.sub)
            Cycle0: begin
               DpCtrl.aluOp = Decoded.aluFn;
               DpCtrl.immSel = Decoded.immSel;
               case (Decoded.cls)
                  ClsAlu: begin
                     DpCtrl.op2Sel = Decoded.op2Sel;
                     DpCtrl.rs1Sel = Decoded.rs1Sel;
                     DpCtrl.regWe = Decoded.regWrite;
                     DpCtrl.pcWe = 1'b1;
                     FlagWe = Decoded.flagUpdate;
                     if (Decoded.flagUpdate)
                        DpCtrl.pcEn = 1'b1;    // PC out onto sysbus
                     else
                        DpCtrl.aluEn = 1'b1;   // Immediate loads drive the bus
                  end
                  ClsMem: begin
                     DpCtrl.aluEn = 1'b1;      // Address add before bus cycle
                     DpCtrl.aluWe = 1'b1;
                  end
                  default: begin
                     DpCtrl.pcWe = 1'b1;
                     case (Decoded.branch)
                        RET: begin
                           DpCtrl.aluOp = FnA;
                           DpCtrl.lrEn = 1'b1;
                           DpCtrl.pcSel = PcSysbus;
                        end
                        JMP: DpCtrl.pcSel = PcAluOut;
                        default: begin
                           DpCtrl.op1Sel = Op1Pc;
                           DpCtrl.aluEn = 1'b1;
                           if (BranchTaken) begin
                              DpCtrl.pcSel = PcAluOut;
                              if (Decoded.branch == BWL) begin
                                 DpCtrl.lrWe = 1'b1;   // Save return address
                                 DpCtrl.lrSel = LrPc;
                              end
                           end
                        end
                     endcase
                  end
               endcase
            end
            Cycle1: begin
               MemCtrl.ale = 1'b1;
               MemCtrl.nWE = 1'b1;
               MemCtrl.nOE = 1'b1;
               DpCtrl.aluOp = Decoded.aluFn;
               DpCtrl.immSel = Decoded.immSel;
               DpCtrl.aluEn = 1'b1;
            end
            Cycle2: begin
               MemCtrl.nME = 1'b0;
               MemCtrl.nWE = 1'b1;
               DpCtrl.rs1Sel = Rs1Rd;       // Rd passes through the ALU
               DpCtrl.aluWe = 1'b1;
               DpCtrl.aluEn = 1'b1;
               if (Decoded.opcode == LDW)
                  MemCtrl.memEn = 1'b1;
               else
                  MemCtrl.nOE = 1'b1;
            end
            Cycle3: begin
               MemCtrl.nME = 1'b0;
               if (Decoded.opcode == LDW) begin
                  MemCtrl.memEn = 1'b1;
                  MemCtrl.enb = 1'b1;
                  MemCtrl.nWE = 1'b1;
               end else begin
                  MemCtrl.nOE = 1'b1;
                  DpCtrl.aluEn = 1'b1;      // Hold store data on sysbus
               end
            end
            default: begin
               DpCtrl.pcWe = 1'b1;
               if (Decoded.opcode == LDW) begin
                  MemCtrl.nWE = 1'b1;
                  MemCtrl.memEn = 1'b1;
                  DpCtrl.wdSel = WdSys;
                  DpCtrl.regWe = 1'b1;
               end else begin
                  MemCtrl.nOE = 1'b1;
                  DpCtrl.aluEn = 1'b1;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- files.f
design/controlPkg.sv
design/instrDecode.sv
design/cycleSequencer.sv
design/statusFlags.sv
design/strobeGen.sv
design/cpuControl.sv
verif/cpuControlTb.sv

//--- verif/cpuControlTb.sv
// Testbench for the instruction control unit, random instructions against a cycle reference
`default_nettype none

module cpuControlTb;

   import controlPkg::*;

   typedef struct packed {
      dpCtrlT  dp;
      memCtrlT mem;
   } expectT;

   logic              Clock;
   logic              nReset;
   logic              nWait;
   logic [7:0]        OpcodeCondIn;
   logic [FlagsW-1:0] Flags;
   dpCtrlT            DpCtrl;
   memCtrlT           MemCtrl;
   logic              CFlag;

   cpuControl cpuControl_i (
      .Clock        (Clock),
      .nReset       (nReset),
      .nWait        (nWait),
      .OpcodeCondIn (OpcodeCondIn),
      .Flags        (Flags),
      .DpCtrl       (DpCtrl),
      .MemCtrl      (MemCtrl),
      .CFlag        (CFlag)
   );

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   // Expected control words for an instruction byte, a sequencer position and the status register
   function automatic expectT expectedCtrl(input logic [7:0] instr, input seqStateT st,
                                           input logic [FlagsW-1:0] fl);
      expectT e;
      opcodeT op;
      branchT br;
      logic   ld;
      logic   taken;
      op = opcodeT'(instr[7:3]);
      br = branchT'(instr[2:0]);
      ld = op == LDW;
      e.dp = DpIdle;
      e.mem = MemIdle;
      if (st.major == Fetch) begin
         e.mem.nWE = 1'b1;
         e.mem.ale = st.sub == Cycle0;
         e.mem.nOE = st.sub == Cycle0;
         e.dp.pcEn = st.sub == Cycle0;
         e.mem.nME = !(st.sub inside {Cycle1, Cycle2});
         e.mem.memEn = st.sub != Cycle0;
         e.mem.enb = st.sub == Cycle2;
         e.dp.irWe = st.sub == Cycle3;
      end else if (op inside {LDW, STW}) begin
         e.dp.aluOp = (st.sub <= Cycle1) ? FnADD : FnA;           // Address add
         e.dp.immSel = (st.sub <= Cycle1) ? ImmShort : ImmLong;
         e.dp.aluEn = (st.sub <= Cycle2) || !ld;
         e.dp.aluWe = st.sub inside {Cycle0, Cycle2};
         e.dp.rs1Sel = (st.sub == Cycle2) ? Rs1Rd : Rs1Ra;
         e.dp.pcWe = st.sub == Cycle4;
         e.dp.regWe = ld && (st.sub == Cycle4);
         e.dp.wdSel = (ld && (st.sub == Cycle4)) ? WdSys : WdAlu;
         e.mem.ale = st.sub == Cycle1;
         e.mem.nWE = (st.sub inside {Cycle1, Cycle2}) || (ld && (st.sub >= Cycle3));
         e.mem.nOE = (st.sub == Cycle1) || (!ld && (st.sub >= Cycle2));
         e.mem.nME = !(st.sub inside {Cycle2, Cycle3});
         e.mem.memEn = ld && (st.sub >= Cycle2);
         e.mem.enb = ld && (st.sub == Cycle3);
      end else if (op == BRANCH) begin
         case (br)
            BR, BWL: taken = 1'b1;
            BNE:     taken = !fl[FlagZ];
            BE:      taken = fl[FlagZ];
            BLT:     taken = fl[FlagN] != fl[FlagV];
            BGE:     taken = fl[FlagN] == fl[FlagV];
            default: taken = 1'b0;
         endcase
         e.dp.pcWe = 1'b1;
         e.dp.aluOp = (br == RET) ? FnA : FnADD;
         e.dp.immSel = (br == JMP) ? ImmShort : ImmLong;
         if (br == RET) begin
            e.dp.lrEn = 1'b1;                                    // Return address from LR
            e.dp.pcSel = PcSysbus;
         end else if (br == JMP) begin
            e.dp.pcSel = PcAluOut;
         end else begin
            e.dp.op1Sel = Op1Pc;
            e.dp.aluEn = 1'b1;
            e.dp.pcSel = taken ? PcAluOut : Pc1;
            e.dp.lrWe = taken && (br == BWL);
            e.dp.lrSel = (taken && (br == BWL)) ? LrPc : LrSys;
         end
      end else begin
         case (op)
            ADD, ADDI, ADDIB:            e.dp.aluOp = FnADD;
            ADC, ADCI:                   e.dp.aluOp = FnADC;
            SUB, SUBI, SUBIB, CMP, CMPI: e.dp.aluOp = FnSUB;
            SUC, SUCI:                   e.dp.aluOp = FnSUC;
            AND:                         e.dp.aluOp = FnAND;
            OR:                          e.dp.aluOp = FnOR;
            XOR:                         e.dp.aluOp = FnXOR;
            NOT:                         e.dp.aluOp = FnNOT;
            NAND:                        e.dp.aluOp = FnNAND;
            NOR:                         e.dp.aluOp = FnNOR;
            LSL:                         e.dp.aluOp = FnLSL;
            LSR:                         e.dp.aluOp = FnLSR;
            ASR:                         e.dp.aluOp = FnASR;
            NEG:                         e.dp.aluOp = FnNEG;
            LUI:                         e.dp.aluOp = FnLUI;
            LLI:                         e.dp.aluOp = FnLLI;
            default:                     e.dp.aluOp = FnA;
         endcase
         e.dp.pcWe = 1'b1;
         e.dp.op2Sel = (op inside {ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR}) ?
                       Op2Rd2 : Op2Imm;
         e.dp.immSel = (op inside {ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR}) ?
                       ImmShort : ImmLong;
         e.dp.rs1Sel = (op inside {ADDIB, SUBIB, LUI, LLI}) ? Rs1Rd : Rs1Ra;
         e.dp.regWe = !(op inside {CMP, CMPI});
         e.dp.pcEn = !(op inside {LUI, LLI});
         e.dp.aluEn = op inside {LUI, LLI};                      // Immediate load drives sysbus
      end
      return e;
   endfunction

   task automatic abortRun();
      $display("Simulation FAILED");
      $fatal(1, "Stopped at the first failing check");
   endtask

   task automatic checkDp(input string name, input dpCtrlT got, input dpCtrlT exp);
      if (got !== exp) begin
         $display("ERROR %s at %0t: got %h, expected %h", name, $time, got, exp);
         abortRun();
      end
   endtask

   task automatic checkMem(input string name, input memCtrlT got, input memCtrlT exp);
      if (got !== exp) begin
         $display("ERROR %s at %0t: got %h, expected %h", name, $time, got, exp);
         abortRun();
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s at %0t: got %h, expected %h", name, $time, got, exp);
         abortRun();
      end
   endtask

   task automatic stepClock();
      @(posedge Clock);
      nWait <= ($urandom_range(3) != 0);                         // Low about one cycle in four
   endtask

   task automatic waitForStrobe(input logic wantIr);
      for (int n = 0; n < 64; n++) begin
         @(negedge Clock);
         if (wantIr ? DpCtrl.irWe : DpCtrl.pcWe)
            return;
         stepClock();
      end
      $display("Timeout: no %s pulse within 64 cycles", wantIr ? "irWe" : "pcWe");
      abortRun();
   endtask

   // Cycle walker, tracks fetch and execute and checks every output in every cycle
   initial begin : walker
      seqStateT          st;
      logic [FlagsW-1:0] modelFlags;
      expectT            e;
      opcodeT            op;
      logic              stall;
      logic              last;
      st = SeqStart;
      modelFlags = '0;
      @(posedge Clock);                                          // First check on a real falling edge
      forever begin
         @(negedge Clock);
         op = opcodeT'(OpcodeCondIn[7:3]);
         e = expectedCtrl(OpcodeCondIn, st, modelFlags);
         checkDp("DpCtrl", DpCtrl, e.dp);
         checkMem("MemCtrl", MemCtrl, e.mem);
         checkBit("CFlag", CFlag, modelFlags[FlagC]);
         if (nReset) begin
            if (st.major == Execute && st.sub == Cycle0 && op <= NEG)
               modelFlags = Flags;
            stall = !nWait && ((st.major == Fetch) ? st.sub == Cycle2 : st.sub == Cycle3);
            last = (st.major == Fetch) ? st.sub == Cycle3 :
                   (st.sub == Cycle4 || !(op inside {LDW, STW}));
            if (last && st.major == Fetch)
               st = '{major: Execute, sub: Cycle0};
            else if (last)
               st = SeqStart;
            else if (!stall)
               st.sub = subCycleT'(st.sub + 1);
         end
      end
   end

   initial begin : stimulus
      logic [7:0] instr;
      void'($urandom(32'hbeed2858));
      nReset = 1'b0;
      nWait = 1'b1;
      OpcodeCondIn = '0;
      Flags = '0;
      repeat (10) @(posedge Clock);
      nReset <= 1'b1;
      // Four passes over all opcodes, then branches behind random flag-setting ops
      for (int i = 0; i < 4 * 27 + 128; i++) begin
         instr[2:0] = 3'($urandom_range(7));
         if (i < 4 * 27)
            instr[7:3] = 5'(i % 27);
         else if (i % 2 == 0)
            instr[7:3] = 5'($urandom_range(NEG));
         else
            instr[7:3] = 5'(BRANCH);
         OpcodeCondIn <= instr;
         Flags <= FlagsW'($urandom_range(15));
         nWait <= ($urandom_range(3) != 0);
         waitForStrobe(1'b1);
         stepClock();
         waitForStrobe(1'b0);
         stepClock();
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire
